// File: spi_cfg_pkg.sv
`default_nettype none

package spi_cfg_pkg;

    // Word and chip-select geometry
    localparam int SPI_DATA_W     = 8;
    localparam int SPI_MAX_SLAVES = 4;
    localparam int SPI_SEL_W      = 2;

    // Smallest serial clock period in clk cycles
    localparam logic [15:0] SPI_MIN_DIV = 16'd2;

    typedef struct packed {
        logic cpol;
        logic cpha;
    } spi_mode_t;

    typedef struct packed {
        spi_mode_t            mode;
        // Serial clock period in clk cycles
        logic [15:0]          clk_div;
        logic [SPI_SEL_W-1:0] def_sel;
    } spi_cfg_t;

    // Configuration after reset: mode 0, divide by 4, slave 0
    localparam spi_cfg_t SPI_CFG_RESET = '{
        mode:    '{cpol: 1'b0, cpha: 1'b0},
        clk_div: 16'd4,
        def_sel: '0
    };

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        TRANSFER,
        COMPLETE
    } spi_state_t;

endpackage

`default_nettype wire

// File: spi_cmd_pkg.sv
`default_nettype none

package spi_cmd_pkg;

    // Code 2'd3 is left undefined
    typedef enum logic [1:0] {
        OP_CONFIG       = 2'd0,
        OP_XFER         = 2'd1,
        OP_XFER_DEFAULT = 2'd2
    } spi_opcode_t;

    typedef struct packed {
        spi_opcode_t                        opcode;
        logic [spi_cfg_pkg::SPI_SEL_W-1:0]  sel;
        logic [spi_cfg_pkg::SPI_DATA_W-1:0] tx_data;
        spi_cfg_pkg::spi_cfg_t              cfg;
    } spi_cmd_t;

    typedef enum logic [1:0] {
        ST_OK        = 2'd0,
        ST_BAD_OP    = 2'd1,
        ST_BAD_SLAVE = 2'd2
    } spi_status_t;

    typedef struct packed {
        spi_status_t                        status;
        logic [spi_cfg_pkg::SPI_SEL_W-1:0]  sel;
        logic [spi_cfg_pkg::SPI_DATA_W-1:0] rx_data;
    } spi_rsp_t;

    // Work order from decoder to master
    typedef struct packed {
        logic [spi_cfg_pkg::SPI_SEL_W-1:0]  sel;
        logic [spi_cfg_pkg::SPI_DATA_W-1:0] tx_data;
        spi_cfg_pkg::spi_cfg_t              cfg;
    } spi_xfer_t;

    typedef enum logic {
        DEC_IDLE,
        DEC_ACK
    } dec_state_t;

    typedef enum logic [1:0] {
        RES_IDLE,
        RES_REQ,
        RES_WAIT
    } res_state_t;

endpackage

`default_nettype wire

// File: spi_cmd_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module spi_cmd_decoder
    import spi_cfg_pkg::*, spi_cmd_pkg::*;
#(
    parameter int NUM_SLAVES = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  spi_cmd_t             cmd,
    input  logic                 cmd_req,
    input  logic                 busy,
    input  logic                 rsp_pending,
    output logic                 cmd_ack,
    output spi_xfer_t            xfer,
    output logic                 start,
    output logic                 post,
    output spi_status_t          post_status,
    output logic [SPI_SEL_W-1:0] post_sel
);

    if (NUM_SLAVES < 1 || NUM_SLAVES > SPI_MAX_SLAVES) begin : g_num_slaves_check
        $error("spi_cmd_decoder: NUM_SLAVES out of range");
    end

    dec_state_t            state_q;
    spi_cfg_t              cfg_q;
    logic [SPI_SEL_W-1:0]  sel_q;
    logic [SPI_DATA_W-1:0] tx_q;

    logic                 accept;
    logic [SPI_SEL_W-1:0] target_sel;
    logic                 sel_ok;
    logic [15:0]          new_div;

    // One command in flight, and the previous response must be gone
    assign accept = (state_q == DEC_IDLE) && cmd_req && !busy && !rsp_pending;

    assign target_sel = (cmd.opcode == OP_XFER_DEFAULT) ? cfg_q.def_sel : cmd.sel;
    assign sel_ok     = int'(target_sel) < NUM_SLAVES;

    // Divider below the minimum would give no half period
    assign new_div = (cmd.cfg.clk_div < SPI_MIN_DIV) ? SPI_MIN_DIV : cmd.cfg.clk_div;

    assign cmd_ack = (state_q == DEC_ACK);
    assign xfer    = '{sel: sel_q, tx_data: tx_q, cfg: cfg_q};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= DEC_IDLE;
            cfg_q   <= SPI_CFG_RESET;
            start   <= 1'b0;
            post    <= 1'b0;
        end else begin
            start <= 1'b0;
            post  <= 1'b0;
            case (state_q)
                DEC_IDLE: begin
                    if (accept) begin
                        state_q <= DEC_ACK;
                        case (cmd.opcode)
                            OP_CONFIG: begin
                                cfg_q.mode    <= cmd.cfg.mode;
                                cfg_q.clk_div <= new_div;
                                cfg_q.def_sel <= cmd.cfg.def_sel;
                                post          <= 1'b1;
                            end
                            OP_XFER, OP_XFER_DEFAULT: begin
                                if (sel_ok) begin
                                    start <= 1'b1;
                                end else begin
                                    post <= 1'b1;
                                end
                            end
                            default: begin
                                post <= 1'b1;
                            end
                        endcase
                    end
                end
                DEC_ACK: begin
                    if (!cmd_req) begin
                        state_q <= DEC_IDLE;
                    end
                end
                default: begin
                    state_q <= DEC_IDLE;
                end
            endcase
        end
    end

    // Transfer payload and the status of commands that end here
    always_ff @(posedge clk) begin
        if (accept) begin
            case (cmd.opcode)
                OP_CONFIG: begin
                    post_status <= ST_OK;
                    post_sel    <= cmd.cfg.def_sel;
                end
                OP_XFER, OP_XFER_DEFAULT: begin
                    sel_q       <= target_sel;
                    tx_q        <= cmd.tx_data;
                    post_status <= ST_BAD_SLAVE;
                    post_sel    <= target_sel;
                end
                default: begin
                    post_status <= ST_BAD_OP;
                    post_sel    <= cmd.sel;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: spi_master.sv
`timescale 1ns/10ps
`default_nettype none

module spi_master
    import spi_cfg_pkg::*, spi_cmd_pkg::*;
#(
    parameter int NUM_SLAVES = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  spi_xfer_t             xfer,
    input  logic                  start,
    input  logic                  spi_miso,
    output logic                  busy,
    output logic                  done,
    output logic [SPI_DATA_W-1:0] rx_data,
    output logic                  spi_clk,
    output logic                  spi_mosi,
    output logic [NUM_SLAVES-1:0] spi_cs_n
);

    localparam int CNT_W = $clog2(SPI_DATA_W);

    spi_state_t state_q;
    spi_state_t state_d;

    // Captured transfer
    spi_mode_t             mode_q;
    logic [15:0]           div_q;
    logic [SPI_SEL_W-1:0]  sel_q;
    logic [SPI_DATA_W-1:0] tx_sh;
    logic [SPI_DATA_W-1:0] rx_sh;

    logic [15:0]      div_cnt;
    logic [CNT_W-1:0] bit_cnt;

    logic lead_ev;
    logic trail_ev;
    logic sample_ev;
    logic shift_ev;
    logic last_bit;

    // Leading edge at mid period, trailing edge at period end
    assign lead_ev  = (state_q == TRANSFER) && (div_cnt == (div_q >> 1) - 16'd1);
    assign trail_ev = (state_q == TRANSFER) && (div_cnt == div_q - 16'd1);

    // CPHA 1 moves data on the leading edge and samples on the trailing one
    assign sample_ev = mode_q.cpha ? trail_ev : lead_ev;
    assign shift_ev  = mode_q.cpha ? lead_ev : trail_ev;

    assign last_bit = (bit_cnt == CNT_W'(SPI_DATA_W - 1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start) begin
                    state_d = SETUP;
                end
            end
            SETUP: begin
                state_d = TRANSFER;
            end
            TRANSFER: begin
                if (trail_ev && last_bit) begin
                    state_d = COMPLETE;
                end
            end
            COMPLETE: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q  <= IDLE;
            mode_q   <= '0;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            spi_clk  <= 1'b0;
            spi_mosi <= 1'b0;
        end else begin
            state_q <= state_d;

            // Idle clock level follows the live configuration
            if (state_q == IDLE) begin
                mode_q  <= xfer.cfg.mode;
                spi_clk <= xfer.cfg.mode.cpol;
            end else if (lead_ev) begin
                spi_clk <= ~mode_q.cpol;
            end else if (trail_ev) begin
                spi_clk <= mode_q.cpol;
            end

            if (state_q == TRANSFER) begin
                div_cnt <= trail_ev ? '0 : div_cnt + 16'd1;
                if (trail_ev) begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                div_cnt <= '0;
                bit_cnt <= '0;
            end

            // MSB goes out at SETUP for CPHA 0, at the first leading edge otherwise
            if (state_q == IDLE && start && !xfer.cfg.mode.cpha) begin
                spi_mosi <= xfer.tx_data[SPI_DATA_W-1];
            end else if (shift_ev) begin
                spi_mosi <= tx_sh[SPI_DATA_W-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE) begin
            sel_q <= xfer.sel;
            div_q <= xfer.cfg.clk_div;
            if (xfer.cfg.mode.cpha) begin
                tx_sh <= xfer.tx_data;
            end else begin
                tx_sh <= {xfer.tx_data[SPI_DATA_W-2:0], 1'b0};
            end
        end else if (shift_ev) begin
            tx_sh <= {tx_sh[SPI_DATA_W-2:0], 1'b0};
        end

        if (sample_ev) begin
            rx_sh <= {rx_sh[SPI_DATA_W-2:0], spi_miso};
        end
    end

    // Selected slave held low from SETUP through COMPLETE
    always_comb begin
        spi_cs_n = '1;
        if (state_q != IDLE) begin
            for (int i = 0; i < NUM_SLAVES; i++) begin
                if (int'(sel_q) == i) begin
                    spi_cs_n[i] = 1'b0;
                end
            end
        end
    end

    assign busy    = (state_q != IDLE);
    assign done    = (state_q == COMPLETE);
    assign rx_data = rx_sh;

endmodule

`default_nettype wire

// File: spi_result_unit.sv
`timescale 1ns/10ps
`default_nettype none

module spi_result_unit
    import spi_cfg_pkg::*, spi_cmd_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  done,
    input  logic [SPI_DATA_W-1:0] rx_data,
    input  logic                  post,
    input  spi_status_t           post_status,
    input  logic [SPI_SEL_W-1:0]  post_sel,
    input  logic [SPI_SEL_W-1:0]  xfer_sel,
    input  logic                  rsp_ack,
    output spi_rsp_t              rsp,
    output logic                  rsp_req,
    output logic                  rsp_pending
);

    res_state_t state_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= RES_IDLE;
        end else begin
            case (state_q)
                RES_IDLE: begin
                    if (done || post) begin
                        state_q <= RES_REQ;
                    end
                end
                RES_REQ: begin
                    if (rsp_ack) begin
                        state_q <= RES_WAIT;
                    end
                end
                RES_WAIT: begin
                    // Handshake ends once the host drops ack
                    if (!rsp_ack) begin
                        state_q <= RES_IDLE;
                    end
                end
                default: begin
                    state_q <= RES_IDLE;
                end
            endcase
        end
    end

    // Response register, loaded only when idle
    always_ff @(posedge clk) begin
        if (state_q == RES_IDLE) begin
            if (done) begin
                rsp <= '{status: ST_OK, sel: xfer_sel, rx_data: rx_data};
            end else if (post) begin
                rsp <= '{status: post_status, sel: post_sel, rx_data: '0};
            end
        end
    end

    assign rsp_req     = (state_q == RES_REQ);
    assign rsp_pending = (state_q != RES_IDLE);

endmodule

`default_nettype wire

// File: spi_subsystem_top.sv
`timescale 1ns/10ps
`default_nettype none

module spi_subsystem_top
    import spi_cfg_pkg::*, spi_cmd_pkg::*;
#(
    parameter int NUM_SLAVES = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    // Host command port
    input  spi_cmd_t              cmd,
    input  logic                  cmd_req,
    output logic                  cmd_ack,
    // Host response port
    output spi_rsp_t              rsp,
    output logic                  rsp_req,
    input  logic                  rsp_ack,
    // Serial bus
    output logic                  spi_clk,
    output logic                  spi_mosi,
    input  logic                  spi_miso,
    output logic [NUM_SLAVES-1:0] spi_cs_n
);

    spi_xfer_t             xfer;
    logic                  start;
    logic                  busy;
    logic                  done;
    logic [SPI_DATA_W-1:0] rx_data;
    logic                  post;
    spi_status_t           post_status;
    logic [SPI_SEL_W-1:0]  post_sel;
    logic                  rsp_pending;

    spi_cmd_decoder #(
        .NUM_SLAVES (NUM_SLAVES)
    ) u_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd         (cmd),
        .cmd_req     (cmd_req),
        .busy        (busy),
        .rsp_pending (rsp_pending),
        .cmd_ack     (cmd_ack),
        .xfer        (xfer),
        .start       (start),
        .post        (post),
        .post_status (post_status),
        .post_sel    (post_sel)
    );

    spi_master #(
        .NUM_SLAVES (NUM_SLAVES)
    ) u_master (
        .clk      (clk),
        .rst_n    (rst_n),
        .xfer     (xfer),
        .start    (start),
        .spi_miso (spi_miso),
        .busy     (busy),
        .done     (done),
        .rx_data  (rx_data),
        .spi_clk  (spi_clk),
        .spi_mosi (spi_mosi),
        .spi_cs_n (spi_cs_n)
    );

    spi_result_unit u_result (
        .clk         (clk),
        .rst_n       (rst_n),
        .done        (done),
        .rx_data     (rx_data),
        .post        (post),
        .post_status (post_status),
        .post_sel    (post_sel),
        .xfer_sel    (xfer.sel),
        .rsp_ack     (rsp_ack),
        .rsp         (rsp),
        .rsp_req     (rsp_req),
        .rsp_pending (rsp_pending)
    );

endmodule

`default_nettype wire

// File: spi_properties.sv
`timescale 1ns/10ps
`default_nettype none

module spi_properties
    import spi_cfg_pkg::*;
#(
    parameter int NUM_SLAVES = 4
) (
    input logic                  clk,
    input logic                  rst_n,
    input spi_state_t            state,
    input logic                  cpol,
    input logic                  busy,
    input logic                  done,
    input logic                  spi_clk,
    input logic [NUM_SLAVES-1:0] spi_cs_n
);

    // Failure count, summed into the final report
    int unsigned fails = 0;

    one_cs_low: assert property (@(posedge clk) disable iff (!rst_n)
        $countones(~spi_cs_n) <= 1)
        else begin
            fails++;
            $error("more than one chip select low");
        end

    // Busy only with a slave selected
    idle_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (&spi_cs_n) |-> ((state == IDLE) && !busy))
        else begin
            fails++;
            $error("master busy with no slave selected");
        end

    done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else begin
            fails++;
            $error("done held for more than one cycle");
        end

    // Serial clock parked at CPOL when deselected
    clk_idle_level: assert property (@(posedge clk) disable iff (!rst_n)
        (&spi_cs_n) |-> (spi_clk == cpol))
        else begin
            fails++;
            $error("spi_clk differs from CPOL with no slave selected");
        end

endmodule

bind spi_master spi_properties #(
    .NUM_SLAVES (NUM_SLAVES)
) u_props (
    .clk      (clk),
    .rst_n    (rst_n),
    .state    (state_q),
    .cpol     (mode_q.cpol),
    .busy     (busy),
    .done     (done),
    .spi_clk  (spi_clk),
    .spi_cs_n (spi_cs_n)
);

`default_nettype wire

// File: tb_spi_subsystem.sv
`timescale 1ns/10ps
`default_nettype none

// Slave that answers with the last word it received, MSB first
module spi_slave_model
    import spi_cfg_pkg::*;
#(
    parameter logic [SPI_DATA_W-1:0] INIT = '0
) (
    input  logic spi_clk,
    input  logic spi_mosi,
    input  logic cs_n,
    input  logic cpol,
    input  logic cpha,
    output logic miso
);

    logic [SPI_DATA_W-1:0] word = INIT;
    logic [SPI_DATA_W-1:0] in_sh;
    logic [SPI_DATA_W-1:0] out_sh;
    logic                  cs_q = 1'b1;

    initial miso = 1'b0;

    always @(spi_clk or cs_n) begin
        if (cs_n === 1'b0 && cs_q !== 1'b0) begin
            out_sh = word;
            // CPHA 0 has the MSB on the wire before the first edge
            if (!cpha) begin
                miso   = out_sh[SPI_DATA_W-1];
                out_sh = out_sh << 1;
            end
        end else if (cs_n === 1'b1 && cs_q === 1'b0) begin
            word = in_sh;
        end else if (cs_n === 1'b0) begin
            if ((spi_clk != cpol) ^ cpha) begin
                in_sh = {in_sh[SPI_DATA_W-2:0], spi_mosi};
            end else begin
                miso   = out_sh[SPI_DATA_W-1];
                out_sh = out_sh << 1;
            end
        end
        cs_q = cs_n;
    end

endmodule

module tb_spi_subsystem
    import spi_cfg_pkg::*, spi_cmd_pkg::*;
();

    localparam int NSLV     = 3;
    localparam int MAX_DIV  = 8;
    localparam int NUM_CMDS = 38;

    typedef struct packed {
        spi_rsp_t        rsp;
        logic [NSLV-1:0] cs_mask;
        int              lat;
    } exp_t;

    logic            clk = 1'b0;
    logic            rst_n;
    spi_cmd_t        cmd;
    logic            cmd_req;
    logic            cmd_ack;
    spi_rsp_t        rsp;
    logic            rsp_req;
    logic            rsp_ack;
    logic            spi_clk;
    logic            spi_mosi;
    logic            spi_miso;
    logic [NSLV-1:0] spi_cs_n;
    logic [NSLV-1:0] slave_miso;

    integer                seed = 32'hd6ce;
    int                    errors = 0;
    int                    n_cmds = 0;
    int                    n_rsps = 0;
    int                    cyc = 0;
    int                    t_ack = 0;
    logic                  ack_q = 1'b0;
    logic                  req_q = 1'b0;
    logic [NSLV-1:0]       cs_seen = '0;
    exp_t                  exp_q[$];
    spi_cfg_t              ref_cfg;
    logic [SPI_DATA_W-1:0] slave_word[NSLV];

    always #5 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    spi_subsystem_top #(
        .NUM_SLAVES (NSLV)
    ) DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd      (cmd),
        .cmd_req  (cmd_req),
        .cmd_ack  (cmd_ack),
        .rsp      (rsp),
        .rsp_req  (rsp_req),
        .rsp_ack  (rsp_ack),
        .spi_clk  (spi_clk),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso),
        .spi_cs_n (spi_cs_n)
    );

    for (genvar i = 0; i < NSLV; i++) begin : g_slave
        spi_slave_model #(
            .INIT (SPI_DATA_W'(8'h5A ^ i))
        ) u_slave (
            .spi_clk  (spi_clk),
            .spi_mosi (spi_mosi),
            .cs_n     (spi_cs_n[i]),
            .cpol     (ref_cfg.mode.cpol),
            .cpha     (ref_cfg.mode.cpha),
            .miso     (slave_miso[i])
        );
    end

    assign spi_miso = |(slave_miso & ~spi_cs_n);

    // Expected response, chip-select use and ack-to-req cycles of a command
    function automatic exp_t ref_rsp(spi_cmd_t c);
        exp_t                 e;
        logic [SPI_SEL_W-1:0] tgt;
        tgt = (c.opcode == OP_XFER_DEFAULT) ? ref_cfg.def_sel : c.sel;
        e.rsp.sel     = tgt;
        e.rsp.rx_data = '0;
        e.cs_mask     = '0;
        e.lat         = 1;
        case (c.opcode)
            OP_CONFIG: begin
                e.rsp.status = ST_OK;
                e.rsp.sel    = c.cfg.def_sel;
            end
            OP_XFER, OP_XFER_DEFAULT: begin
                if (int'(tgt) < NSLV) begin
                    e.rsp.status  = ST_OK;
                    e.rsp.rx_data = slave_word[tgt];
                    e.cs_mask[tgt] = 1'b1;
                    e.lat = SPI_DATA_W * int'(ref_cfg.clk_div) + 3;
                end else begin
                    e.rsp.status = ST_BAD_SLAVE;
                end
            end
            default: e.rsp.status = ST_BAD_OP;
        endcase
        return e;
    endfunction

    function automatic spi_cmd_t cfg_cmd(logic cpol, logic cpha, logic [15:0] div,
                                         logic [SPI_SEL_W-1:0] def_sel);
        spi_cmd_t c;
        c = '0;
        c.opcode      = OP_CONFIG;
        c.cfg.mode    = '{cpol: cpol, cpha: cpha};
        c.cfg.clk_div = div;
        c.cfg.def_sel = def_sel;
        return c;
    endfunction

    function automatic spi_cmd_t xfer_cmd(spi_opcode_t op, logic [SPI_SEL_W-1:0] sel);
        spi_cmd_t c;
        c = '0;
        c.opcode  = op;
        c.sel     = sel;
        c.tx_data = SPI_DATA_W'($random(seed));
        return c;
    endfunction

    task automatic check_rsp_status(input spi_status_t got, input spi_status_t exp);
        if (got !== exp) begin
            errors++;
            $display("error rsp.status got %h expected %h", got, exp);
        end
    endtask

    task automatic check_rsp_data(input logic [SPI_DATA_W-1:0] got,
                                  input logic [SPI_DATA_W-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error rsp.rx_data got %h expected %h", got, exp);
        end
    endtask

    task automatic check_rsp_sel(input logic [SPI_SEL_W-1:0] got,
                                 input logic [SPI_SEL_W-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error rsp.sel got %h expected %h", got, exp);
        end
    endtask

    task automatic check_cs_mask(input logic [NSLV-1:0] got, input logic [NSLV-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error spi_cs_n low mask got %h expected %h", got, exp);
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("error ack-to-rsp_req cycles got %h expected %h", got, exp);
        end
    endtask

    always @(posedge clk) begin : compare_rsp
        exp_t e;
        if (rst_n) begin
            cs_seen = cs_seen | ~spi_cs_n;
        end
        if (cmd_ack && !ack_q) begin
            t_ack = cyc;
        end
        if (rsp_req && !req_q) begin
            n_rsps++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("a response arrived with no command outstanding");
            end else begin
                e = exp_q.pop_front();
                check_rsp_status(rsp.status, e.rsp.status);
                check_rsp_sel(rsp.sel, e.rsp.sel);
                check_rsp_data(rsp.rx_data, e.rsp.rx_data);
                check_cs_mask(cs_seen, e.cs_mask);
                check_latency(cyc - t_ack, e.lat);
            end
            cs_seen = '0;
        end
        ack_q = cmd_ack;
        req_q = rsp_req;
    end

    task automatic raise_cmd(input spi_cmd_t c);
        exp_t e;
        e = ref_rsp(c);
        exp_q.push_back(e);
        if (e.cs_mask != '0) begin
            slave_word[e.rsp.sel] = c.tx_data;
        end
        if (c.opcode == OP_CONFIG) begin
            ref_cfg = c.cfg;
        end
        n_cmds++;
        @(posedge clk);
        cmd     <= c;
        cmd_req <= 1'b1;
    endtask

    task automatic finish_cmd();
        do @(posedge clk); while (!cmd_ack);
        cmd_req <= 1'b0;
        do @(posedge clk); while (cmd_ack);
    endtask

    task automatic take_rsp(input int delay);
        while (!rsp_req) @(posedge clk);
        repeat (delay) @(posedge clk);
        rsp_ack <= 1'b1;
        do @(posedge clk); while (rsp_req);
        rsp_ack <= 1'b0;
    endtask

    task automatic run_cmd(input spi_cmd_t c, input int delay);
        raise_cmd(c);
        finish_cmd();
        take_rsp(delay);
    endtask

    // Next command waits behind a response the host has not taken yet
    task automatic stall_cmd(input spi_cmd_t c, input int hold);
        while (!rsp_req) @(posedge clk);
        raise_cmd(c);
        repeat (hold) begin
            @(posedge clk);
            if (cmd_ack) begin
                errors++;
                $display("cmd_ack rose while the previous response was still unacknowledged");
            end
        end
        take_rsp(0);
        finish_cmd();
    endtask

    initial begin : watchdog
        repeat (NUM_CMDS * (8 * MAX_DIV + 40)) @(posedge clk);
        $display("timeout: the test did not finish within the cycle limit");
        $display("** FAIL **");
        $finish;
    end

    initial begin : main
        int assert_fails;
        rst_n   = 1'b0;
        cmd     = '0;
        cmd_req = 1'b0;
        rsp_ack = 1'b0;
        ref_cfg = SPI_CFG_RESET;
        for (int i = 0; i < NSLV; i++) begin
            slave_word[i] = SPI_DATA_W'(8'h5A ^ i);
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        if (cmd_ack !== 1'b0 || rsp_req !== 1'b0 || spi_cs_n !== '1 || spi_clk !== 1'b0) begin
            errors++;
            $display("outputs are not at their reset values after reset");
        end

        // Every mode, random slaves, then the default slave
        for (int m = 0; m < 4; m++) begin
            run_cmd(cfg_cmd(m[1], m[0], (m == 0) ? 16'd4 : 16'(2 + {$random(seed)} % 7),
                            SPI_SEL_W'(m % NSLV)), 0);
            repeat (4) begin
                run_cmd(xfer_cmd(OP_XFER, SPI_SEL_W'({$random(seed)} % NSLV)),
                        {$random(seed)} % 4);
            end
            run_cmd(xfer_cmd(OP_XFER_DEFAULT, '0), 0);
        end

        // Rejected commands
        run_cmd(xfer_cmd(spi_opcode_t'(2'd3), 2'd1), 0);
        run_cmd(xfer_cmd(spi_opcode_t'(2'd3), 2'd3), 0);
        run_cmd(xfer_cmd(OP_XFER, 2'd3), 0);
        run_cmd(cfg_cmd(1'b0, 1'b1, 16'd3, 2'd3), 0);
        run_cmd(xfer_cmd(OP_XFER_DEFAULT, '0), 0);
        run_cmd(cfg_cmd(1'b1, 1'b0, 16'd4, 2'd2), 0);

        // Back-pressure on the response port
        raise_cmd(xfer_cmd(OP_XFER, SPI_SEL_W'({$random(seed)} % NSLV)));
        finish_cmd();
        repeat (7) begin
            stall_cmd(xfer_cmd(spi_opcode_t'(2'd1 + 2'({$random(seed)} % 2)),
                               SPI_SEL_W'({$random(seed)} % 4)),
                      1 + {$random(seed)} % 15);
        end
        take_rsp(0);

        repeat (4) @(posedge clk);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d responses never arrived", exp_q.size());
        end
        assert_fails = DUT.u_master.u_props.fails;
        $display("commands %0d, responses %0d, check errors %0d, assertion failures %0d",
                 n_cmds, n_rsps, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
spi_cfg_pkg.sv
spi_cmd_pkg.sv
spi_cmd_decoder.sv
spi_master.sv
spi_result_unit.sv
spi_subsystem_top.sv
spi_properties.sv
tb_spi_subsystem.sv
